//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int data_width = 16;
    localparam int reg_count = 8;
    localparam int reg_addr_width = $clog2(reg_count);
    localparam int dmem_words = 32;
    localparam int dmem_addr_width = $clog2(dmem_words);
    localparam int opcode_width = 5;
    localparam int imm_width = 8;

    // Codes that are not listed here are treated as nop by the decoder.
    typedef enum logic [opcode_width-1:0] {
        op_add   = 5'd0,
        op_sub   = 5'd1,
        op_and   = 5'd2,
        op_not   = 5'd3,
        op_inc   = 5'd4,
        op_dec   = 5'd5,
        op_or    = 5'd6,
        op_xor   = 5'd7,
        op_shl   = 5'd8,
        op_shr   = 5'd9,
        op_load  = 5'd12,
        op_store = 5'd13,
        op_ldi   = 5'd14,
        op_nop   = 5'd31
    } opcode_e;

    // Single-operand instructions use ra only and leave rb unused.
    function automatic logic is_single_operand(input opcode_e op);
        case (op)
            op_not, op_inc, op_dec, op_shl, op_shr, op_ldi: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    typedef struct packed {
        logic                      valid;
        opcode_e                   op;
        logic [reg_addr_width-1:0] dest;
        logic [data_width-1:0]     op_a;
        logic [data_width-1:0]     op_b;
        logic [reg_addr_width-1:0] src_a;
        logic [reg_addr_width-1:0] src_b;
        logic [imm_width-1:0]      imm;
    } decoded_t;

    // For load and store, result carries the data memory address.
    typedef struct packed {
        logic                      valid;
        opcode_e                   op;
        logic [reg_addr_width-1:0] dest;
        logic                      writes_reg;
        logic [data_width-1:0]     result;
        logic [data_width-1:0]     store_data;
    } exec_t;

    typedef struct packed {
        logic                      valid;
        logic [reg_addr_width-1:0] dest;
        logic [data_width-1:0]     data;
    } retire_t;

endpackage

`default_nettype wire

//--- regfile/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file
    import cpu_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic [reg_addr_width-1:0] read_addr_a,
    input  logic [reg_addr_width-1:0] read_addr_b,
    input  logic                      single_operand,
    output logic [data_width-1:0]     read_data_a,
    output logic [data_width-1:0]     read_data_b,
    input  retire_t                   write
);

    logic [data_width-1:0] regs [reg_count];

    // A register being written in this cycle is read with its new value.
    function automatic logic [data_width-1:0] read_port(
        input logic [reg_addr_width-1:0] addr
    );
        logic [data_width-1:0] value;
        value = regs[addr];
        if (write.valid && write.dest == addr) begin
            value = write.data;
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (write.valid) begin
            regs[write.dest] <= write.data;
        end
    end

    logic [data_width-1:0] data_a;
    logic [data_width-1:0] data_b;

    always_comb begin
        data_a = read_port(read_addr_a);
        data_b = read_port(read_addr_b);
    end

    assign read_data_a = data_a;

    // Single-operand ops see the first operand on both ports.
    assign read_data_b = single_operand ? data_a : data_b;

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage
    import cpu_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      instr_valid,
    input  logic [data_width-1:0]     instr,
    output logic [reg_addr_width-1:0] read_addr_a,
    output logic [reg_addr_width-1:0] read_addr_b,
    output logic                      single_operand,
    input  logic [data_width-1:0]     read_data_a,
    input  logic [data_width-1:0]     read_data_b,
    output decoded_t                  decoded
);

    logic [opcode_width-1:0]   op_field;
    logic [reg_addr_width-1:0] ra;
    logic [reg_addr_width-1:0] rb;
    opcode_e                   op;
    decoded_t                  decoded_next;

    assign op_field = instr[15:11];
    assign ra = instr[10:8];
    assign rb = instr[7:5];

    always_comb begin
        case (op_field)
            op_add, op_sub, op_and, op_not, op_inc, op_dec, op_or, op_xor,
            op_shl, op_shr, op_load, op_store, op_ldi: op = opcode_e'(op_field);
            default: op = op_nop;
        endcase
    end

    assign single_operand = is_single_operand(op);
    assign read_addr_a = ra;
    assign read_addr_b = rb;

    always_comb begin
        decoded_next.valid = instr_valid;
        decoded_next.op = op;
        decoded_next.dest = ra;
        decoded_next.op_a = read_data_a;
        decoded_next.op_b = read_data_b;
        decoded_next.src_a = ra;
        // Port b carried ra's value, so forwarding must track ra as well.
        decoded_next.src_b = single_operand ? ra : rb;
        decoded_next.imm = instr[imm_width-1:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded.valid <= 1'b0;
        end else begin
            decoded <= decoded_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  decoded_t decoded,
    input  retire_t  retire,
    output exec_t    executed
);

    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic [data_width-1:0] alu_result;
    exec_t                 executed_next;

    // The newest producer wins. A load still in this stage has no data yet,
    // which is the load delay slot.
    function automatic logic [data_width-1:0] forward_operand(
        input logic [reg_addr_width-1:0] src,
        input logic [data_width-1:0]     decoded_value
    );
        logic [data_width-1:0] value;
        value = decoded_value;
        if (executed.valid && executed.writes_reg && executed.op != op_load
                && executed.dest == src) begin
            value = executed.result;
        end else if (retire.valid && retire.dest == src) begin
            value = retire.data;
        end
        return value;
    endfunction

    always_comb begin
        a = forward_operand(decoded.src_a, decoded.op_a);
        b = forward_operand(decoded.src_b, decoded.op_b);
    end

    always_comb begin
        case (decoded.op)
            op_add:   alu_result = a + b;
            op_sub:   alu_result = a - b;
            op_and:   alu_result = a & b;
            op_or:    alu_result = a | b;
            op_xor:   alu_result = a ^ b;
            op_not:   alu_result = ~a;
            op_inc:   alu_result = a + 1'b1;
            op_dec:   alu_result = a - 1'b1;
            op_shl:   alu_result = a << 1;
            op_shr:   alu_result = a >> 1;
            op_ldi:   alu_result = {{(data_width-imm_width){1'b0}}, decoded.imm};
            op_load,
            op_store: alu_result = b;
            default:  alu_result = '0;
        endcase
    end

    always_comb begin
        executed_next.valid = decoded.valid;
        executed_next.op = decoded.op;
        executed_next.dest = decoded.dest;
        executed_next.writes_reg = (decoded.op != op_store) && (decoded.op != op_nop);
        executed_next.result = alu_result;
        executed_next.store_data = a;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            executed.valid <= 1'b0;
        end else begin
            executed <= executed_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/memory_stage.sv
`timescale 1ns/10ps
`default_nettype none

module memory_stage
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  exec_t   executed,
    output retire_t retire
);

    logic [data_width-1:0]      dmem [dmem_words];
    logic [dmem_addr_width-1:0] addr;
    logic [data_width-1:0]      load_data;

    // Only the low address bits select a word.
    assign addr = executed.result[dmem_addr_width-1:0];
    assign load_data = dmem[addr];

    always_ff @(posedge clk) begin
        if (executed.valid && executed.op == op_store) begin
            dmem[addr] <= executed.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= executed.valid && executed.writes_reg;
            retire.dest <= executed.dest;
            if (executed.op == op_load) begin
                retire.data <= load_data;
            end else begin
                retire.data <= executed.result;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instr_valid,
    input  logic [data_width-1:0] instr,
    output retire_t               retire
);

    logic [reg_addr_width-1:0] read_addr_a;
    logic [reg_addr_width-1:0] read_addr_b;
    logic                      single_operand;
    logic [data_width-1:0]     read_data_a;
    logic [data_width-1:0]     read_data_b;
    decoded_t                  decoded;
    exec_t                     executed;

    reg_file u_reg_file (
        .clk            (clk),
        .reset          (reset),
        .read_addr_a    (read_addr_a),
        .read_addr_b    (read_addr_b),
        .single_operand (single_operand),
        .read_data_a    (read_data_a),
        .read_data_b    (read_data_b),
        .write          (retire)
    );

    decode_stage u_decode_stage (
        .clk            (clk),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .read_addr_a    (read_addr_a),
        .read_addr_b    (read_addr_b),
        .single_operand (single_operand),
        .read_data_a    (read_data_a),
        .read_data_b    (read_data_b),
        .decoded        (decoded)
    );

    execute_stage u_execute_stage (
        .clk      (clk),
        .reset    (reset),
        .decoded  (decoded),
        .retire   (retire),
        .executed (executed)
    );

    // The retire register is also the register file write port.
    memory_stage u_memory_stage (
        .clk      (clk),
        .reset    (reset),
        .executed (executed),
        .retire   (retire)
    );

endmodule

`default_nettype wire

//--- testbench/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_tb
    import cpu_pkg::*;
();

    typedef struct packed {
        logic [31:0] due;
        logic [2:0]  dest;
        logic [15:0] data;
    } expect_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        instr_valid;
    logic [15:0] instr;
    retire_t     retire;

    expect_t     expected [$];
    expect_t     head;
    logic [15:0] model_regs [8];
    logic [15:0] model_mem [32];
    logic [31:0] mem_written;
    logic [31:0] cycle = '0;
    logic [31:0] rand_state = 32'h73fa_5048;
    int          mismatch_errors = 0;
    int          other_errors = 0;
    int          retired_count = 0;

    cpu_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .retire      (retire)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic random_word(output logic [31:0] value);
        rand_state = lcg_next(rand_state);
        value = rand_state;
    endtask

    // The first ten codes are the ALU ops, two-operand ones first.
    function automatic logic [4:0] any_op(input logic [3:0] sel);
        case (sel)
            4'd0: return op_add;
            4'd1: return op_sub;
            4'd2: return op_and;
            4'd3: return op_or;
            4'd4: return op_xor;
            4'd5: return op_not;
            4'd6: return op_inc;
            4'd7: return op_dec;
            4'd8: return op_shl;
            4'd9: return op_shr;
            4'd10: return op_load;
            4'd11: return op_store;
            4'd14: return op_nop;
            4'd15: return 5'd20;
            default: return op_ldi;
        endcase
    endfunction

    // Runs the instruction on the sequential model and drives it to the DUT.
    task automatic issue(input logic [4:0] op, input logic [2:0] ra, input logic [7:0] low);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] result;
        logic        writes;
        expect_t     entry;
        @(negedge clk);
        a = model_regs[ra];
        b = model_regs[low[7:5]];
        result = '0;
        writes = 1'b1;
        case (op)
            op_add: result = a + b;
            op_sub: result = a - b;
            op_and: result = a & b;
            op_or: result = a | b;
            op_xor: result = a ^ b;
            op_not: result = ~a;
            op_inc: result = a + 16'd1;
            op_dec: result = a - 16'd1;
            op_shl: result = {a[14:0], 1'b0};
            op_shr: result = {1'b0, a[15:1]};
            op_load: result = model_mem[b[4:0]];
            op_ldi: result = {8'h00, low};
            op_store: begin
                model_mem[b[4:0]] = a;
                mem_written[b[4:0]] = 1'b1;
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes) begin
            model_regs[ra] = result;
            entry.due = cycle + 32'd3;
            entry.dest = ra;
            entry.data = result;
            expected.push_back(entry);
        end
        instr = {op, ra, low};
        instr_valid = 1'b1;
        if (op == op_load) begin
            // Load delay slot.
            @(negedge clk);
            instr = {op_nop, 11'd0};
        end
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(negedge clk);
            instr_valid = 1'b0;
            instr = '0;
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (expected.size() > 0 && waited < 20) begin
            idle_cycles(1);
            waited++;
        end
        if (expected.size() > 0) begin
            other_errors++;
            $display("timeout: %0d expected retires never arrived", expected.size());
        end
    endtask

    always @(negedge clk) begin
        if (cycle > 0) begin
            if (expected.size() > 0 && expected[0].due == cycle) begin
                head = expected.pop_front();
                retired_count++;
                assert (retire.valid === 1'b1) else begin
                    other_errors++;
                    $display("missing retire for r%0d at cycle %0d", head.dest, cycle);
                end
                if (retire.valid === 1'b1) begin
                    assert (retire.dest === head.dest) else begin
                        mismatch_errors++;
                        $display("mismatch retire.dest: got %h expected %h",
                                 retire.dest, head.dest);
                    end
                    assert (retire.data === head.data) else begin
                        mismatch_errors++;
                        $display("mismatch retire.data: got %h expected %h",
                                 retire.data, head.data);
                    end
                end
            end else begin
                assert (retire.valid === 1'b0) else begin
                    other_errors++;
                    $display("unexpected retire of r%0d at cycle %0d", retire.dest, cycle);
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [4:0]  op;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        model_regs = '{default: '0};
        model_mem = '{default: '0};
        mem_written = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        idle_cycles(6);

        // Every register reads as zero after reset.
        for (int i = 0; i < 8; i++) begin
            issue(op_inc, i[2:0], 8'd0);
        end

        for (int i = 0; i < 8; i++) begin
            random_word(r);
            issue(op_ldi, i[2:0], r[23:16]);
        end
        for (int j = 0; j < 10; j++) begin
            for (int k = 0; k < 4; k++) begin
                random_word(r);
                issue(any_op(j[3:0]), r[26:24], r[23:16]);
            end
        end

        // Dependent pairs at distances one to three.
        for (int d = 1; d <= 3; d++) begin
            random_word(r);
            issue(op_ldi, 3'd1, r[23:16]);
            repeat (d - 1) issue(op_nop, 3'd0, 8'd0);
            issue(op_add, 3'd2, {3'd1, 5'd0});
            repeat (d - 1) issue(op_nop, 3'd0, 8'd0);
            issue(op_sub, 3'd2, {3'd3, 5'd0});
            issue(op_inc, 3'd2, 8'd0);
        end

        for (int i = 0; i < 6; i++) begin
            random_word(r);
            issue(op_ldi, 3'd5, r[23:16]);
            issue(op_ldi, 3'd6, r[31:24]);
            issue(op_shl, 3'd6, 8'd0);
            issue(op_store, 3'd6, {3'd5, 5'd0});
            issue(op_xor, 3'd6, {3'd6, 5'd0});
            issue(op_load, 3'd7, {3'd5, 5'd0});
            issue(op_add, 3'd7, {3'd7, 5'd0});
        end

        for (int i = 0; i < 320; i++) begin
            random_word(r);
            op = any_op(r[31:28]);
            if (op == op_load && !mem_written[model_regs[r[23:21]][4:0]]) begin
                op = op_store;
            end
            issue(op, r[26:24], r[23:16]);
        end

        wait_for_drain();
        idle_cycles(4);
        $display("errors: %0d mismatches, %0d other failures, %0d retires checked",
                 mismatch_errors, other_errors, retired_count);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
common/cpu_pkg.sv
regfile/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_top.sv
testbench/cpu_tb.sv

//--- Makefile
SOURCES := $(shell cat sim.f)

.PHONY: run clean

run: obj_dir/Vcpu_tb
	out=$$(./obj_dir/Vcpu_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

obj_dir/Vcpu_tb: sim.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module cpu_tb -f sim.f -o Vcpu_tb

clean:
	rm -rf obj_dir
